/* Bender.yml */
package:
  name: core_control

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - core_control_cycle.sv
  - core_control_writeback.sv
  - core_reg_file.sv
  - core_control_top.sv
  - target: test
    files:
      - core_control_tb.sv

/* core_control_cycle.sv */
`include "core_defines.svh"

module core_control_cycle (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                issue,
	input  logic                dec_mem,
	input  logic                dec_base_wb,
	input  logic                dec_mul,
	input  logic                mem_ready,
	input  logic                exc_req,

	output core_pkg::cycle_kind cycle,
	output core_pkg::cycle_kind next_cycle
);

	logic                base_wb_pending;
	core_pkg::cycle_kind seq_next;

	// Sequence of cycles as the instruction stream alone would have it.
	always_comb begin
		seq_next = core_pkg::cyc_issue;
		case (cycle)
			core_pkg::cyc_issue: begin
				// Memory wins if the decoder flags both kinds.
				if (issue && dec_mem)
					seq_next = core_pkg::cyc_transfer;
				else if (issue && dec_mul)
					seq_next = core_pkg::cyc_mul;
			end
			core_pkg::cyc_transfer: begin
				if (!mem_ready)
					seq_next = core_pkg::cyc_transfer;
				else if (base_wb_pending)
					seq_next = core_pkg::cyc_base_wb;
			end
			core_pkg::cyc_mul: begin
				seq_next = core_pkg::cyc_mul_hi_wb;
			end
			default: begin
				seq_next = core_pkg::cyc_issue;
			end
		endcase
	end

	// Exception entry only slips in where an issue cycle would come next.
	always_comb begin
		next_cycle = seq_next;
		if (seq_next == core_pkg::cyc_issue && exc_req)
			next_cycle = core_pkg::cyc_exception;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= core_pkg::cyc_issue;
			base_wb_pending <= 1'b0;
		end else begin
			cycle <= next_cycle;
			if (cycle == core_pkg::cyc_issue && issue && dec_mem)
				base_wb_pending <= dec_base_wb;
		end
	end

	a_cycle_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		cycle inside {core_pkg::cyc_issue, core_pkg::cyc_transfer,
			core_pkg::cyc_base_wb, core_pkg::cyc_mul,
			core_pkg::cyc_mul_hi_wb, core_pkg::cyc_exception}
	);

	// The high word of a multiply is written right after the low word.
	a_mul_hi_after_mul: assert property (
		@(posedge clk) disable iff (!rst_n)
		cycle == core_pkg::cyc_mul_hi_wb |-> $past(cycle) == core_pkg::cyc_mul
	);

endmodule

/* core_control_tb.sv */
`include "core_defines.svh"

module core_control_tb;

	localparam int PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_CYCLES = 4000;
	// One cycle per random slot, plus reset and a wide margin.
	localparam int TIMEOUT = (NUM_CYCLES + RESET_CYCLES + 50) * PERIOD * 2;

	logic clk, rst_n;
	logic issue, dec_writeback, dec_update_flags, dec_mem, dec_store, dec_base_wb, dec_mul;
	logic mem_ready, exc_req, wb_en;
	core_pkg::reg_num dec_rd, dec_rn, dec_rd_hi, rs, wb_rd;
	core_pkg::word q_alu, ldst_read, saved_base, mul_q_hi, mul_q_lo, vector;
	core_pkg::word rs_value, wb_value;
	core_pkg::psr_flags alu_flags, flags;

	// Reference model state.
	core_pkg::cycle_kind m_kind, exp_next;
	core_pkg::reg_num m_rd, m_rn, m_rd_hi, exp_rd;
	logic m_store, m_base, m_alu_wr, m_flag_pend, accept, exp_en;
	core_pkg::psr_flags m_flag_val, m_flags;
	core_pkg::word m_regs [`CORE_NUM_REGS];
	core_pkg::word exp_val, exp_rs;
	logic [5:0] seen;
	logic [31:0] seed;

	core_control_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always_comb begin
		exp_next = core_pkg::cyc_issue;
		case (m_kind)
			core_pkg::cyc_issue: begin
				if (issue && dec_mem)
					exp_next = core_pkg::cyc_transfer;
				else if (issue && dec_mul)
					exp_next = core_pkg::cyc_mul;
			end
			core_pkg::cyc_transfer: begin
				if (!mem_ready)
					exp_next = core_pkg::cyc_transfer;
				else if (m_base)
					exp_next = core_pkg::cyc_base_wb;
			end
			core_pkg::cyc_mul: exp_next = core_pkg::cyc_mul_hi_wb;
			default: exp_next = core_pkg::cyc_issue;
		endcase
		// An exception request takes over the slot of the next issue cycle.
		if (exp_next == core_pkg::cyc_issue && exc_req)
			exp_next = core_pkg::cyc_exception;
		accept = m_kind == core_pkg::cyc_issue && issue && exp_next != core_pkg::cyc_exception;

		exp_en = 1'b0;
		exp_rd = m_rd;
		exp_val = q_alu;
		case (m_kind)
			core_pkg::cyc_issue: exp_en = m_alu_wr;
			core_pkg::cyc_transfer: begin
				exp_en = mem_ready && !m_store;
				exp_val = ldst_read;
			end
			core_pkg::cyc_base_wb: begin
				exp_en = 1'b1;
				exp_rd = m_rn;
				exp_val = saved_base;
			end
			core_pkg::cyc_mul: begin
				exp_en = 1'b1;
				exp_val = mul_q_lo;
			end
			core_pkg::cyc_mul_hi_wb: begin
				exp_en = 1'b1;
				exp_rd = m_rd_hi;
				exp_val = mul_q_hi;
			end
			default: begin
				exp_en = 1'b1;
				exp_rd = `CORE_R15;
				exp_val = vector;
			end
		endcase
		exp_rs = (exp_en && exp_rd == rs) ? exp_val : m_regs[rs];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_kind <= core_pkg::cyc_issue;
			{m_rd, m_rn, m_rd_hi, m_store, m_base, m_alu_wr} <= '0;
			{m_flag_pend, m_flag_val, m_flags, seen} <= '0;
			for (int i = 0; i < `CORE_NUM_REGS; i++)
				m_regs[i] <= '0;
		end else begin
			if (exp_en)
				m_regs[exp_rd] <= exp_val;
			if (m_flag_pend)
				m_flags <= m_flag_val;
			m_alu_wr <= accept && dec_writeback && !dec_mem && !dec_mul;
			m_flag_pend <= accept && dec_update_flags;
			if (accept) begin
				{m_rd, m_rn, m_rd_hi} <= {dec_rd, dec_rn, dec_rd_hi};
				{m_store, m_base, m_flag_val} <= {dec_store, dec_base_wb, alu_flags};
			end
			m_kind <= exp_next;
			seen <= seen | {m_kind == core_pkg::cyc_exception, m_kind == core_pkg::cyc_mul_hi_wb,
				m_kind == core_pkg::cyc_base_wb, m_kind == core_pkg::cyc_transfer && exp_en,
				m_flag_pend, m_kind == core_pkg::cyc_issue && issue && !accept};
		end
	end

	task automatic report_mismatch(input string what);
		$display("ERR %0t: %s", $time, what);
		$display("Regression failed");
		$fatal(1);
	endtask

	a_wb_en: assert property (@(posedge clk) disable iff (!rst_n) wb_en == exp_en)
		else report_mismatch("write enable differs from the model");
	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> wb_rd == exp_rd && wb_value == exp_val)
		else report_mismatch("write register or value differs from the model");
	a_rs_value: assert property (@(posedge clk) disable iff (!rst_n) rs_value == exp_rs)
		else report_mismatch("read port value differs from the model");
	a_flags: assert property (@(posedge clk) disable iff (!rst_n) flags == m_flags)
		else report_mismatch("flags differ from the model");

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		r = next_rand();
		issue = r[31];
		dec_mem = r[30:29] == 2'd2;
		dec_mul = r[30:29] == 2'd3;
		{dec_writeback, dec_update_flags, dec_store, dec_base_wb} = r[28:25];
		// Memory answers about one cycle in four, so loads wait a random time.
		mem_ready = r[24:23] == 2'b11;
		exc_req = r[22:19] == 4'd0;
		r = next_rand();
		{dec_rd, dec_rn, dec_rd_hi, rs, alu_flags} = r[31:12];
		q_alu = next_rand();
		ldst_read = next_rand();
		saved_base = next_rand();
		mul_q_hi = next_rand();
		mul_q_lo = next_rand();
		vector = next_rand();
	endtask

	initial begin
		#(TIMEOUT);
		$display("Timeout: the random run did not finish in time");
		$display("Regression failed");
		$fatal(1);
	end

	initial begin
		seed = 32'hdad68149;
		rst_n = 1'b0;
		{issue, dec_writeback, dec_update_flags, dec_mem, dec_store, dec_base_wb, dec_mul} = '0;
		{mem_ready, exc_req, dec_rd, dec_rn, dec_rd_hi, rs, alu_flags} = '0;
		{q_alu, ldst_read, saved_base, mul_q_hi, mul_q_lo, vector} = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (NUM_CYCLES) begin
			@(negedge clk);
			drive_random();
		end
		repeat (2) @(negedge clk);
		if (seen != '1) begin
			$display("Not every kind of write was exercised, seen = %b", seen);
			$display("Regression failed");
			$fatal(1);
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* core_control_top.sv */
module core_control_top (
	input  logic               clk,
	input  logic               rst_n,

	input  core_pkg::reg_num   dec_rd,
	input  core_pkg::reg_num   dec_rn,
	input  core_pkg::reg_num   dec_rd_hi,
	input  logic               dec_writeback,
	input  logic               dec_update_flags,
	input  logic               dec_mem,
	input  logic               dec_store,
	input  logic               dec_base_wb,
	input  logic               dec_mul,
	input  logic               issue,

	input  core_pkg::word      q_alu,
	input  core_pkg::psr_flags alu_flags,
	input  logic               mem_ready,
	input  core_pkg::word      ldst_read,
	input  core_pkg::word      saved_base,
	input  core_pkg::word      mul_q_hi,
	input  core_pkg::word      mul_q_lo,
	input  logic               exc_req,
	input  core_pkg::word      vector,

	input  core_pkg::reg_num   rs,
	output core_pkg::word      rs_value,
	output core_pkg::psr_flags flags,

	output logic               wb_en,
	output core_pkg::reg_num   wb_rd,
	output core_pkg::word      wb_value
);

	core_pkg::cycle_kind cycle;
	core_pkg::cycle_kind next_cycle;
	logic                update_flags;
	core_pkg::psr_flags  wb_alu_flags;

	core_control_cycle u_cycle (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue       (issue),
		.dec_mem     (dec_mem),
		.dec_base_wb (dec_base_wb),
		.dec_mul     (dec_mul),
		.mem_ready   (mem_ready),
		.exc_req     (exc_req),
		.cycle       (cycle),
		.next_cycle  (next_cycle)
	);

	core_control_writeback u_writeback (
		.clk              (clk),
		.rst_n            (rst_n),
		.cycle            (cycle),
		.next_cycle       (next_cycle),
		.issue            (issue),
		.dec_writeback    (dec_writeback),
		.dec_update_flags (dec_update_flags),
		.dec_store        (dec_store),
		.mem_ready        (mem_ready),
		.dec_rd           (dec_rd),
		.dec_rn           (dec_rn),
		.dec_rd_hi        (dec_rd_hi),
		.q_alu            (q_alu),
		.ldst_read        (ldst_read),
		.saved_base       (saved_base),
		.mul_q_hi         (mul_q_hi),
		.mul_q_lo         (mul_q_lo),
		.vector           (vector),
		.alu_flags        (alu_flags),
		.rd               (wb_rd),
		.writeback        (wb_en),
		.update_flags     (update_flags),
		.wr_value         (wb_value),
		.wb_alu_flags     (wb_alu_flags)
	);

	core_reg_file u_reg_file (
		.clk          (clk),
		.rst_n        (rst_n),
		.rd           (wb_rd),
		.writeback    (wb_en),
		.update_flags (update_flags),
		.wr_value     (wb_value),
		.wb_alu_flags (wb_alu_flags),
		.rs           (rs),
		.rs_value     (rs_value),
		.flags        (flags)
	);

endmodule

/* core_control_writeback.sv */
`include "core_defines.svh"

module core_control_writeback (
	input  logic                clk,
	input  logic                rst_n,

	input  core_pkg::cycle_kind cycle,
	input  core_pkg::cycle_kind next_cycle,

	input  logic                issue,
	input  logic                dec_writeback,
	input  logic                dec_update_flags,
	input  logic                dec_store,
	input  logic                mem_ready,

	input  core_pkg::reg_num    dec_rd,
	input  core_pkg::reg_num    dec_rn,
	input  core_pkg::reg_num    dec_rd_hi,

	input  core_pkg::word       q_alu,
	input  core_pkg::word       ldst_read,
	input  core_pkg::word       saved_base,
	input  core_pkg::word       mul_q_hi,
	input  core_pkg::word       mul_q_lo,
	input  core_pkg::word       vector,
	input  core_pkg::psr_flags  alu_flags,

	output core_pkg::reg_num    rd,
	output logic                writeback,
	output logic                update_flags,
	output core_pkg::word       wr_value,
	output core_pkg::psr_flags  wb_alu_flags
);

	logic             taken;
	logic             issued;
	logic             final_writeback;
	logic             final_update_flags;
	logic             final_store;
	core_pkg::reg_num final_rd;
	core_pkg::reg_num base_rd;
	core_pkg::reg_num hi_rd;

	// An issue strobe counts only in an issue cycle that exception entry does not take over.
	assign taken = issue && cycle == core_pkg::cyc_issue &&
		next_cycle != core_pkg::cyc_exception;

	// Select this cycle's write from the kind of cycle and what was latched at issue.
	always_comb begin
		rd = final_rd;
		wr_value = q_alu;
		writeback = 1'b0;
		case (cycle)
			core_pkg::cyc_issue: begin
				writeback = issued && final_writeback;
			end
			core_pkg::cyc_transfer: begin
				wr_value = ldst_read;
				writeback = mem_ready && !final_store;
			end
			core_pkg::cyc_base_wb: begin
				rd = base_rd;
				wr_value = saved_base;
				writeback = 1'b1;
			end
			core_pkg::cyc_mul: begin
				wr_value = mul_q_lo;
				writeback = 1'b1;
			end
			core_pkg::cyc_mul_hi_wb: begin
				rd = hi_rd;
				wr_value = mul_q_hi;
				writeback = 1'b1;
			end
			core_pkg::cyc_exception: begin
				rd = `CORE_R15;
				wr_value = vector;
				writeback = 1'b1;
			end
			default: begin
				writeback = 1'b0;
			end
		endcase
	end

	// Flags land on the edge after the issue cycle, whatever kind of instruction it was.
	assign update_flags = issued && final_update_flags;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issued <= 1'b0;
			final_writeback <= 1'b0;
			final_update_flags <= 1'b0;
			final_store <= 1'b0;
			final_rd <= '0;
			base_rd <= '0;
			hi_rd <= '0;
		end else begin
			issued <= taken;
			if (taken) begin
				final_writeback <= dec_writeback;
				final_update_flags <= dec_update_flags;
				final_store <= dec_store;
				final_rd <= dec_rd;
				base_rd <= dec_rn;
				hi_rd <= dec_rd_hi;
			end
		end
	end

	// Flags produced by the ALU during the issue cycle.
	always_ff @(posedge clk) begin
		if (taken)
			wb_alu_flags <= alu_flags;
	end

	// Exception entry never disturbs the flags.
	a_no_flags_after_exception: assert property (
		@(posedge clk) disable iff (!rst_n)
		cycle == core_pkg::cyc_exception |=> !update_flags
	);

endmodule

/* core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Architectural register count.
`define CORE_NUM_REGS 16

// Data path width.
`define CORE_WORD_W 32

// Width of a register number.
`define CORE_REG_W 4

// The link register.
`define CORE_R14 4'd14

// The PC sits right above the link register.
`define CORE_R15 (`CORE_R14 + 4'd1)

`endif

/* core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

	// One data word as seen by the register file and the write port.
	typedef logic [`CORE_WORD_W-1:0] word;

	// Architectural register number.
	typedef logic [`CORE_REG_W-1:0] reg_num;

	// Condition flags in N, Z, C, V order from the MSB down.
	typedef logic [3:0] psr_flags;

	// Kind of cycle the core is in.
	typedef enum logic [2:0] {
		cyc_issue,
		cyc_transfer,
		cyc_base_wb,
		cyc_mul,
		cyc_mul_hi_wb,
		cyc_exception
	} cycle_kind;

endpackage

/* core_reg_file.sv */
`include "core_defines.svh"

module core_reg_file (
	input  logic               clk,
	input  logic               rst_n,

	input  core_pkg::reg_num   rd,
	input  logic               writeback,
	input  logic               update_flags,
	input  core_pkg::word      wr_value,
	input  core_pkg::psr_flags wb_alu_flags,

	input  core_pkg::reg_num   rs,
	output core_pkg::word      rs_value,
	output core_pkg::psr_flags flags
);

	core_pkg::word regs [`CORE_NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (writeback)
				regs[rd] <= wr_value;
			if (update_flags)
				flags <= wb_alu_flags;
		end
	end

	// A write in flight is forwarded so the reader sees the value the edge will store.
	assign rs_value = (writeback && rd == rs) ? wr_value : regs[rs];

endmodule

/* flist.f */
+incdir+.
core_pkg.sv
core_control_cycle.sv
core_control_writeback.sv
core_reg_file.sv
core_control_top.sv
core_control_tb.sv
